// ==== src/tusca_types_pkg.sv ====
package tusca_types_pkg;

  // serial data byte
  typedef logic [7:0] byte_t;

  // temperature, humidity or limit value
  typedef logic [15:0] value_t;

  // temperature level, 0 to 7
  typedef logic [2:0] level_t;

  typedef enum logic [1:0] {
    st_inicial,
    st_medir,
    st_aguarda, // waiting for the sensor frame
    st_delay
  } uc_state_t;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_t;

endpackage

// ==== src/tusca_timing_pkg.sv ====
package tusca_timing_pkg;

  localparam int BIT_CYCLES   = 8;    // clocks per serial bit
  localparam int GAP_CYCLES   = 200;  // idle clocks before a partial frame is dropped
  localparam int MEDIDA_BYTES = 5;
  localparam int CONFIG_BYTES = 17;
  localparam int DELAY_CYCLES = 3000; // measurement interval and sensor timeout
  localparam int FAN_PERIOD   = 70;
  localparam int FAN_STEP     = 10;   // duty per level
  localparam int SERVO_PERIOD = 200;
  localparam int SERVO_MIN    = 10;
  localparam int SERVO_MAX    = 20;

  localparam int BIT_W        = $clog2(BIT_CYCLES);
  localparam int GAP_W        = $clog2(GAP_CYCLES);
  localparam int DELAY_W      = $clog2(DELAY_CYCLES);
  localparam int FAN_DUTY_W   = $clog2(FAN_PERIOD + 1);
  localparam int SERVO_DUTY_W = $clog2(SERVO_PERIOD + 1);

endpackage

// ==== src/uart_rx.sv ====
module uart_rx import tusca_types_pkg::*, tusca_timing_pkg::*; (
  input  logic  clock,
  input  logic  arst_n,
  input  logic  rx,
  output byte_t byte_data,
  output logic  byte_valid
);

  rx_state_t        state;
  logic [1:0]       rx_sync;
  logic [BIT_W-1:0] os_cnt;  // oversampling counter
  logic [2:0]       bit_cnt;
  byte_t            shreg;

  // two-flop synchronizer, line idles high
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) rx_sync <= 2'b11;
    else         rx_sync <= {rx_sync[0], rx};
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= rx_idle;
      os_cnt     <= '0;
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      os_cnt     <= os_cnt + 1'b1;
      case (state)
        rx_idle: begin
          os_cnt <= '0;
          if (!rx_sync[1]) state <= rx_start;
        end
        rx_start: begin
          if (os_cnt == BIT_W'(BIT_CYCLES / 2 - 1)) begin
            os_cnt  <= '0;
            bit_cnt <= '0;
            state   <= rx_sync[1] ? rx_idle : rx_data; // glitch, not a start bit
          end
        end
        rx_data: begin
          if (os_cnt == BIT_W'(BIT_CYCLES - 1)) begin
            os_cnt  <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= rx_stop;
          end
        end
        rx_stop: begin
          if (os_cnt == BIT_W'(BIT_CYCLES - 1)) begin
            byte_valid <= rx_sync[1]; // bad stop bit drops the byte
            state      <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clock) begin
    if (state == rx_data && os_cnt == BIT_W'(BIT_CYCLES - 1)) shreg <= {rx_sync[1], shreg[7:1]};
  end

  assign byte_data = shreg;

endmodule

// ==== src/frame_receiver.sv ====
module frame_receiver import tusca_types_pkg::*, tusca_timing_pkg::*; #(
  parameter int NBYTES = 5
) (
  input  logic                      clock,
  input  logic                      arst_n,
  input  logic                      clear,
  input  byte_t                     byte_data,
  input  logic                      byte_valid,
  output logic [(NBYTES-1)*8-1:0]   payload,
  output logic                      done,
  output logic                      error
);

  logic [$clog2(NBYTES)-1:0] count;
  logic [GAP_W-1:0]          gap_cnt;
  byte_t                     sum;
  logic                      last_byte;
  logic                      gap_hit;

  assign last_byte = byte_valid && (count == NBYTES - 1);
  assign gap_hit   = (count != '0) && (gap_cnt == GAP_W'(GAP_CYCLES - 1));

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      count   <= '0;
      sum     <= '0;
      gap_cnt <= '0;
      done    <= 1'b0;
      error   <= 1'b0;
    end else begin
      done  <= 1'b0;
      error <= 1'b0;
      if (clear || gap_hit) begin
        count   <= '0;
        sum     <= '0;
        gap_cnt <= '0;
      end else if (byte_valid) begin
        gap_cnt <= '0;
        if (last_byte) begin
          // last byte is the checksum
          done  <= (byte_data == sum);
          error <= (byte_data != sum);
          count <= '0;
          sum   <= '0;
        end else begin
          count <= count + 1'b1;
          sum   <= sum + byte_data;
        end
      end else if (count != '0) begin
        gap_cnt <= gap_cnt + 1'b1;
      end
    end
  end

  // msb first, first byte ends up on top
  always_ff @(posedge clock) begin
    if (byte_valid && !last_byte && !clear) begin
      payload <= {payload[(NBYTES-2)*8-1:0], byte_data};
    end
  end

endmodule

// ==== src/threshold_compare.sv ====
module threshold_compare import tusca_types_pkg::*; (
  input  value_t temp,
  input  value_t umidade,
  input  value_t lim_temp1,
  input  value_t lim_temp2,
  input  value_t lim_temp3,
  input  value_t lim_temp4,
  input  value_t lim_temp5,
  input  value_t lim_temp6,
  input  value_t lim_temp7,
  input  value_t lim_umidade,
  output level_t nivel,
  output logic   rele
);

  value_t lims [7];

  assign lims = '{lim_temp1, lim_temp2, lim_temp3, lim_temp4, lim_temp5, lim_temp6, lim_temp7};

  // number of limits reached, order of limits does not matter
  always_comb begin
    nivel = '0;
    for (int i = 0; i < 7; i++) begin
      if (temp >= lims[i]) nivel = nivel + 1'b1;
    end
  end

  assign rele = (umidade < lim_umidade); // humidifier on while too dry

endmodule

// ==== src/pwm_generator.sv ====
module pwm_generator #(
  parameter int PERIOD = 100
) (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic [$clog2(PERIOD+1)-1:0] duty,
  output logic                        pwm
);

  logic [$clog2(PERIOD)-1:0] cnt;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
      pwm <= 1'b0;
    end else begin
      if (cnt == PERIOD - 1) cnt <= '0;
      else                   cnt <= cnt + 1'b1;
      pwm <= (cnt < duty); // duty cycles high per period
    end
  end

endmodule

// ==== src/tusca_fd.sv ====
module tusca_fd import tusca_types_pkg::*, tusca_timing_pkg::*; (
  input  logic   clock,
  input  logic   arst_n,
  input  logic   gira,
  input  logic   conta_delay,
  input  logic   zera_delay,
  input  logic   medir_dht11,
  input  logic   rx_serial_medida,
  input  logic   rx_serial_config,
  output logic   medir_dht11_out,
  output logic   fim_delay,
  output logic   pronto_medida,
  output logic   erro_medida,
  output logic   pronto_config,
  output logic   erro_config,
  output logic   rele,
  output logic   pwm_ventoinha,
  output logic   pwm_servo,
  output level_t db_nivel_temperatura,
  output value_t db_temperatura,
  output value_t db_umidade
);

  byte_t  byte_medida, byte_config;
  logic   valid_medida, valid_config;
  logic   [(MEDIDA_BYTES-1)*8-1:0] payload_medida;
  logic   [(CONFIG_BYTES-1)*8-1:0] payload_config;
  value_t temp, umidade, lim_umidade;
  value_t lim_temp [7];
  level_t nivel;
  logic   [DELAY_W-1:0]      delay_cnt;
  logic   [FAN_DUTY_W-1:0]   duty_ventoinha;
  logic   [SERVO_DUTY_W-1:0] duty_servo;

  uart_rx rx_medida_i (.clock(clock), .arst_n(arst_n), .rx(rx_serial_medida),
    .byte_data(byte_medida), .byte_valid(valid_medida));

  uart_rx rx_config_i (.clock(clock), .arst_n(arst_n), .rx(rx_serial_config),
    .byte_data(byte_config), .byte_valid(valid_config));

  frame_receiver #(.NBYTES(MEDIDA_BYTES)) frame_medida_i (.clock(clock), .arst_n(arst_n),
    .clear(medir_dht11), .byte_data(byte_medida), .byte_valid(valid_medida),
    .payload(payload_medida), .done(pronto_medida), .error(erro_medida));

  frame_receiver #(.NBYTES(CONFIG_BYTES)) frame_config_i (.clock(clock), .arst_n(arst_n),
    .clear(1'b0), .byte_data(byte_config), .byte_valid(valid_config),
    .payload(payload_config), .done(pronto_config), .error(erro_config));

  // payload order: humidity then temperature, limits 1..7 then humidity limit
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      temp        <= '0;
      umidade     <= '0;
      lim_temp    <= '{default: '1};
      lim_umidade <= '0;
    end else begin
      if (pronto_medida) {umidade, temp} <= payload_medida;
      if (pronto_config) begin
        for (int i = 0; i < 7; i++) lim_temp[i] <= payload_config[127 - 16*i -: 16];
        lim_umidade <= payload_config[15:0];
      end
    end
  end

  threshold_compare cmp_i (.temp(temp), .umidade(umidade), .lim_temp1(lim_temp[0]),
    .lim_temp2(lim_temp[1]), .lim_temp3(lim_temp[2]), .lim_temp4(lim_temp[3]),
    .lim_temp5(lim_temp[4]), .lim_temp6(lim_temp[5]), .lim_temp7(lim_temp[6]),
    .lim_umidade(lim_umidade), .nivel(nivel), .rele(rele));

  // delay counter, wraps at the end
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      delay_cnt       <= '0;
      medir_dht11_out <= 1'b0;
    end else begin
      medir_dht11_out <= medir_dht11;
      if (zera_delay)       delay_cnt <= '0;
      else if (conta_delay) delay_cnt <= fim_delay ? '0 : delay_cnt + 1'b1;
    end
  end

  assign fim_delay = (delay_cnt == DELAY_W'(DELAY_CYCLES - 1));

  assign duty_ventoinha = FAN_DUTY_W'(nivel * FAN_STEP);
  assign duty_servo     = gira ? SERVO_DUTY_W'(SERVO_MAX) : SERVO_DUTY_W'(SERVO_MIN);

  pwm_generator #(.PERIOD(FAN_PERIOD)) pwm_fan_i (.clock(clock), .arst_n(arst_n),
    .duty(duty_ventoinha), .pwm(pwm_ventoinha));

  pwm_generator #(.PERIOD(SERVO_PERIOD)) pwm_servo_i (.clock(clock), .arst_n(arst_n),
    .duty(duty_servo), .pwm(pwm_servo));

  assign db_nivel_temperatura = nivel;
  assign db_temperatura       = temp;
  assign db_umidade           = umidade;

endmodule

// ==== src/tusca_uc.sv ====
module tusca_uc import tusca_types_pkg::*; (
  input  logic clock,
  input  logic arst_n,
  input  logic pronto_medida,
  input  logic erro_medida,
  input  logic fim_delay,
  output logic medir_dht11,
  output logic conta_delay,
  output logic zera_delay,
  output logic gira
);

  uc_state_t state, next_state;
  logic      fim_espera;

  // frame finished, good or bad, or sensor silent too long
  assign fim_espera = pronto_medida || erro_medida || fim_delay;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) state <= st_inicial;
    else         state <= next_state;
  end

  always_comb begin
    next_state = state;
    case (state)
      st_inicial: next_state = st_medir;
      st_medir:   next_state = st_aguarda;
      st_aguarda: if (fim_espera) next_state = st_delay;
      st_delay:   if (fim_delay) next_state = st_medir;
      default:    next_state = st_inicial;
    endcase
  end

  always_comb begin
    medir_dht11 = (state == st_medir);
    conta_delay = (state == st_aguarda) || (state == st_delay);
    // also restart on leaving st_aguarda so st_delay sees a full interval
    zera_delay  = (state == st_medir) || (state == st_aguarda && fim_espera);
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n)            gira <= 1'b0;
    else if (pronto_medida) gira <= ~gira; // servo swaps side per good reading
  end

endmodule

// ==== src/tusca.sv ====
module tusca import tusca_types_pkg::*; (
  input  logic   clock,
  input  logic   arst_n,
  input  logic   rx_serial_medida,
  input  logic   rx_serial_config,
  output logic   medir_dht11_out,
  output logic   pronto_medida,
  output logic   erro_medida,
  output logic   pronto_config,
  output logic   erro_config,
  output logic   rele,
  output logic   pwm_ventoinha,
  output logic   pwm_servo,
  output level_t db_nivel_temperatura,
  output value_t db_temperatura,
  output value_t db_umidade
);

  logic medir_dht11, conta_delay, zera_delay, gira;
  logic fim_delay;

  tusca_uc uc_i (
    .clock         (clock),
    .arst_n        (arst_n),
    .pronto_medida (pronto_medida),
    .erro_medida   (erro_medida),
    .fim_delay     (fim_delay),
    .medir_dht11   (medir_dht11),
    .conta_delay   (conta_delay),
    .zera_delay    (zera_delay),
    .gira          (gira)
  );

  tusca_fd fd_i (
    .clock(clock), .arst_n(arst_n), .gira(gira), .conta_delay(conta_delay),
    .zera_delay(zera_delay), .medir_dht11(medir_dht11),
    .rx_serial_medida(rx_serial_medida), .rx_serial_config(rx_serial_config),
    .medir_dht11_out(medir_dht11_out), .fim_delay(fim_delay),
    .pronto_medida(pronto_medida), .erro_medida(erro_medida),
    .pronto_config(pronto_config), .erro_config(erro_config), .rele(rele),
    .pwm_ventoinha(pwm_ventoinha), .pwm_servo(pwm_servo),
    .db_nivel_temperatura(db_nivel_temperatura), .db_temperatura(db_temperatura),
    .db_umidade(db_umidade)
  );

endmodule

// ==== verification/tusca_tb.sv ====
module tusca_tb import tusca_types_pkg::*, tusca_timing_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int NROWS       = 10;
  localparam int GAP_MAX     = 20;  // idle clocks before a byte, at most
  localparam int FRAME_LIMIT = CONFIG_BYTES * (10 * BIT_CYCLES + GAP_MAX + 1) + 50;
  localparam int WATCHDOG_CYCLES = NROWS * (DELAY_CYCLES + 17 * 10 * BIT_CYCLES)
                                   + 2 * DELAY_CYCLES;

  // vals: measurement uses [0] humidity, [1] temperature; config uses lim1..lim7, lim_umidade
  typedef struct packed {
    logic             is_config;
    logic             corrupt;
    logic [7:0][15:0] vals;
    level_t           exp_nivel;
    logic             exp_rele;
    value_t           exp_temp;
    value_t           exp_umid;
  } row_t;

  logic   clock;
  logic   arst_n;
  logic   rx_serial_medida;
  logic   rx_serial_config;
  logic   medir_dht11_out;
  logic   pronto_medida;
  logic   erro_medida;
  logic   pronto_config;
  logic   erro_config;
  logic   rele;
  logic   pwm_ventoinha;
  logic   pwm_servo;
  level_t db_nivel_temperatura;
  value_t db_temperatura;
  value_t db_umidade;

  row_t rows [NROWS];
  int   errors;
  int   checks;
  int   good_count; // good measurements so far, sets the servo side

  tusca dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic row_t meas_row(input value_t hum, input value_t tmp, input logic bad,
      input level_t nivel, input logic rele_on, input value_t exp_t, input value_t exp_h);
    row_t r;
    r           = '0;
    r.corrupt   = bad;
    r.vals[0]   = hum;
    r.vals[1]   = tmp;
    r.exp_nivel = nivel;
    r.exp_rele  = rele_on;
    r.exp_temp  = exp_t;
    r.exp_umid  = exp_h;
    return r;
  endfunction

  function automatic row_t config_row(input value_t l1, input value_t l2, input value_t l3,
      input value_t l4, input value_t l5, input value_t l6, input value_t l7,
      input value_t lu, input logic bad);
    row_t r;
    r           = '0;
    r.is_config = 1'b1;
    r.corrupt   = bad;
    r.vals      = {lu, l7, l6, l5, l4, l3, l2, l1};
    return r;
  endfunction

  // 0 measurement done/error, 1 config done/error, else the request pulse
  function automatic logic [1:0] pulse_pair(input int kind);
    case (kind)
      0:       return {erro_medida, pronto_medida};
      1:       return {erro_config, pronto_config};
      default: return {1'b0, medir_dht11_out};
    endcase
  endfunction

  task automatic wait_pulse(input int kind, input int limit, output logic [1:0] got);
    int n;
    n   = 0;
    got = 2'b00;
    while (got == 2'b00 && n < limit) begin
      @(negedge clock);
      got = pulse_pair(kind);
      n++;
    end
  endtask

  task automatic drive_line(input logic is_config, input logic v);
    if (is_config) rx_serial_config <= v;
    else           rx_serial_medida <= v;
  endtask

  task automatic send_byte(input logic is_config, input byte_t b);
    logic [9:0] bits;
    int         idle;
    bits = {1'b1, b, 1'b0}; // stop, data lsb first, start
    idle = $urandom % (GAP_MAX + 1);
    repeat (idle) @(posedge clock);
    for (int i = 0; i < 10; i++) begin
      @(posedge clock);
      drive_line(is_config, bits[i]);
      repeat (BIT_CYCLES - 1) @(posedge clock);
    end
  endtask

  task automatic send_frame(input row_t r);
    byte_t sum;
    int    nvals;
    sum   = '0;
    nvals = r.is_config ? 8 : 2;
    for (int k = 0; k < nvals; k++) begin
      send_byte(r.is_config, r.vals[k][15:8]);
      send_byte(r.is_config, r.vals[k][7:0]);
      sum = sum + r.vals[k][15:8] + r.vals[k][7:0];
    end
    if (r.corrupt) sum = ~sum;
    send_byte(r.is_config, sum);
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
      input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_pulse(input string name, input logic [1:0] expected,
      input logic [1:0] got);
    checks++;
    assert (got == expected) else begin
      errors++;
      if (got == 2'b00) $display("ERROR t=%0t: expected pulse on %s never came", $time, name);
      else              $display("FAIL t=%0t %s expected %b got %b", $time, name, expected, got);
    end
  endtask

  task automatic count_high(input logic is_servo, input int cycles, output int highs);
    highs = 0;
    repeat (cycles) begin
      @(negedge clock);
      if (is_servo ? pwm_servo : pwm_ventoinha) highs++;
    end
  endtask

  task automatic run_config(input row_t r);
    logic [1:0] got;
    fork
      send_frame(r);
      wait_pulse(1, FRAME_LIMIT, got);
    join
    check_pulse("{erro_config,pronto_config}", r.corrupt ? 2'b10 : 2'b01, got);
  endtask

  task automatic run_measure(input row_t r);
    logic [1:0] got;
    int         highs;
    wait_pulse(2, 2 * DELAY_CYCLES + 50, got);
    check_pulse("medir_dht11_out", 2'b01, got);
    fork
      send_frame(r);
      wait_pulse(0, FRAME_LIMIT, got);
    join
    check_pulse("{erro_medida,pronto_medida}", r.corrupt ? 2'b10 : 2'b01, got);
    if (!r.corrupt) good_count++;
    @(negedge clock); // registers loaded on the done cycle
    check_value("db_temperatura", r.exp_temp, db_temperatura);
    check_value("db_umidade", r.exp_umid, db_umidade);
    check_value("db_nivel_temperatura", r.exp_nivel, db_nivel_temperatura);
    check_value("rele", r.exp_rele, rele);
    count_high(1'b0, FAN_PERIOD, highs);
    check_value("pwm_ventoinha high cycles", r.exp_nivel * FAN_STEP, highs);
    count_high(1'b1, SERVO_PERIOD, highs);
    check_value("pwm_servo high cycles", good_count[0] ? SERVO_MAX : SERVO_MIN, highs);
  endtask

  initial begin
    void'($urandom(59404));
    arst_n           = 1'b0;
    rx_serial_medida = 1'b1;
    rx_serial_config = 1'b1;
    errors           = 0;
    checks           = 0;
    good_count       = 0;

    // reset limits all ones, humidity limit zero
    rows[0] = meas_row(16'd64, 16'd32, 1'b1, 3'd0, 1'b0, 16'd0, 16'd0);
    rows[1] = meas_row(16'd48, 16'd25, 1'b0, 3'd0, 1'b0, 16'd25, 16'd48);
    rows[2] = config_row(16'd20, 16'd22, 16'd24, 16'd26, 16'd28, 16'd30, 16'd32, 16'd50, 1'b0);
    rows[3] = meas_row(16'd40, 16'd25, 1'b0, 3'd3, 1'b1, 16'd25, 16'd40);
    rows[4] = config_row(16'd10, 16'd11, 16'd12, 16'd13, 16'd14, 16'd15, 16'd16, 16'd30, 1'b1);
    rows[5] = meas_row(16'd45, 16'd28, 1'b0, 3'd5, 1'b1, 16'd28, 16'd45); // old limits
    rows[6] = meas_row(16'd60, 16'd40, 1'b1, 3'd5, 1'b1, 16'd28, 16'd45);
    rows[7] = config_row(16'd100, 16'd200, 16'd300, 16'd400, 16'd500, 16'd600, 16'd700,
                         16'd20, 1'b0);
    rows[8] = meas_row(16'd10, 16'd700, 1'b0, 3'd7, 1'b1, 16'd700, 16'd10);
    rows[9] = meas_row(16'd20, 16'd99, 1'b0, 3'd0, 1'b0, 16'd99, 16'd20);

    repeat (8) @(posedge clock);
    arst_n <= 1'b1;
    @(negedge clock);
    check_value("rele", 1'b0, rele);
    check_value("pwm_servo", 1'b0, pwm_servo);
    check_value("erro_medida", 1'b0, erro_medida);
    check_value("pronto_config", 1'b0, pronto_config);
    check_value("db_nivel_temperatura", 3'd0, db_nivel_temperatura);

    for (int i = 0; i < NROWS; i++) begin
      if (rows[i].is_config) run_config(rows[i]);
      else                   run_measure(rows[i]);
    end

    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("ERROR: watchdog expired before the test sequence finished");
    $display("checks: %0d errors: %0d", checks, errors + 1);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
src/tusca_types_pkg.sv
src/tusca_timing_pkg.sv
src/uart_rx.sv
src/frame_receiver.sv
src/threshold_compare.sv
src/pwm_generator.sv
src/tusca_fd.sv
src/tusca_uc.sv
src/tusca.sv
verification/tusca_tb.sv

// ==== Bender.yml ====
package:
  name: tusca

sources:
  - files:
      - src/tusca_types_pkg.sv
      - src/tusca_timing_pkg.sv
      - src/uart_rx.sv
      - src/frame_receiver.sv
      - src/threshold_compare.sv
      - src/pwm_generator.sv
      - src/tusca_fd.sv
      - src/tusca_uc.sv
      - src/tusca.sv
  - target: test
    files:
      - verification/tusca_tb.sv
